//--- axicb_switch.f
hdl/axicb_pkg.sv
hdl/axicb_pipeline.sv
hdl/axicb_slv_switch.sv
hdl/axicb_mst_switch.sv
hdl/axicb_switch_top.sv
verification/axicb_clk_gen.sv
verification/axicb_switch_tb.sv

//--- hdl/axicb_mst_switch.sv
//////////////////////////////
// Slave-side read switch
//////////////////////////////

module axicb_mst_switch #(
    parameter int MST_NB = 2
) (
    input  logic                                    aclk,
    input  logic                                    i_rst,
    // AR from every master
    input  logic [MST_NB-1:0]                       i_arvalid,
    output logic [MST_NB-1:0]                       o_arready,
    input  logic [MST_NB*axicb_pkg::AXI_ADDR_W-1:0] i_araddr,
    input  logic [MST_NB*axicb_pkg::AXI_ID_W-1:0]   i_arid,
    // AR toward the slave
    output logic                                    o_arvalid,
    input  logic                                    i_arready,
    output logic [axicb_pkg::AXI_ADDR_W-1:0]        o_araddr,
    output logic [axicb_pkg::AXI_ID_W-1:0]          o_arid,
    // R from the slave
    input  logic                                    i_rvalid,
    output logic                                    o_rready,
    input  logic [axicb_pkg::AXI_DATA_W-1:0]        i_rdata,
    input  logic [axicb_pkg::AXI_ID_W-1:0]          i_rid,
    input  logic [axicb_pkg::AXI_RESP_W-1:0]        i_rresp,
    // R back to the masters
    output logic [MST_NB-1:0]                       o_rvalid,
    input  logic [MST_NB-1:0]                       i_rready,
    output logic [axicb_pkg::AXI_DATA_W-1:0]        o_rdata,
    output logic [axicb_pkg::AXI_ID_W-1:0]          o_rid,
    output logic [axicb_pkg::AXI_RESP_W-1:0]        o_rresp
);

    import axicb_pkg::*;

    localparam int PTR_W = (MST_NB > 1) ? $clog2(MST_NB) : 1;

    logic [PTR_W-1:0]     ptr;
    logic [PTR_W-1:0]     rr_idx;
    logic [PTR_W-1:0]     held_idx;
    logic [PTR_W-1:0]     gnt_idx;
    logic                 rr_found;
    logic                 lock;
    logic [MST_IDX_W-1:0] dst;
    logic [MST_NB-1:0]    dst_hit;

    //////////////////////////////
    // Round-robin AR arbiter
    //////////////////////////////

    // Scan downward so the requester closest to ptr wins
    always_comb begin
        int cand;
        rr_found = 1'b0;
        rr_idx = ptr;
        for (int k = MST_NB - 1; k >= 0; k--) begin
            cand = (int'(ptr) + k) % MST_NB;
            if (i_arvalid[cand]) begin
                rr_found = 1'b1;
                rr_idx = PTR_W'(cand);
            end
        end
    end

    // A stalled grant stays with its master until arready
    assign gnt_idx = lock ? held_idx : rr_idx;
    assign o_arvalid = lock | rr_found;
    assign o_araddr = i_araddr[gnt_idx*AXI_ADDR_W +: AXI_ADDR_W];
    assign o_arid = i_arid[gnt_idx*AXI_ID_W +: AXI_ID_W];

    for (genvar m = 0; m < MST_NB; m++) begin : g_arready
        assign o_arready[m] = i_arready && (gnt_idx == PTR_W'(m));
    end

    always_ff @(posedge aclk) begin
        if (i_rst) begin
            ptr <= '0;
            lock <= 1'b0;
            held_idx <= '0;
        end else if (o_arvalid && i_arready) begin
            lock <= 1'b0;
            // Next search starts just past the winner
            if (gnt_idx == PTR_W'(MST_NB - 1)) begin
                ptr <= '0;
            end else begin
                ptr <= gnt_idx + 1'b1;
            end
        end else if (o_arvalid) begin
            lock <= 1'b1;
            held_idx <= gnt_idx;
        end
    end

    //////////////////////////////
    // R routing by ID
    //////////////////////////////

    assign dst = i_rid[MST_ID_LSB +: MST_IDX_W];

    for (genvar m = 0; m < MST_NB; m++) begin : g_rdst
        assign dst_hit[m] = (dst == MST_IDX_W'(m));
    end

    assign o_rvalid = dst_hit & {MST_NB{i_rvalid}};
    // A response with no matching master is drained
    assign o_rready = |(dst_hit & i_rready) | ~|dst_hit;
    assign o_rdata = i_rdata;
    assign o_rid = i_rid;
    assign o_rresp = i_rresp;

endmodule

//--- hdl/axicb_pipeline.sv
//////////////////////////////
// Valid/ready register slice
//////////////////////////////

module axicb_pipeline #(
    parameter int DATA_W = 8,
    parameter int NB_PIPELINE = 0
) (
    input  logic              aclk,
    input  logic              i_rst,
    // Upstream side
    input  logic              i_valid,
    output logic              o_ready,
    input  logic [DATA_W-1:0] i_data,
    // Downstream side
    output logic              o_valid,
    input  logic              i_ready,
    output logic [DATA_W-1:0] o_data
);

    // Index 0 is the input, index NB_PIPELINE the output
    logic [NB_PIPELINE:0]             vld;
    logic [NB_PIPELINE:0]             rdy;
    logic [NB_PIPELINE:0][DATA_W-1:0] dat;

    assign vld[0] = i_valid;
    assign dat[0] = i_data;
    assign o_ready = rdy[0];

    assign o_valid = vld[NB_PIPELINE];
    assign o_data = dat[NB_PIPELINE];
    assign rdy[NB_PIPELINE] = i_ready;

    // With no stage the chain above is plain wires
    for (genvar k = 0; k < NB_PIPELINE; k++) begin : g_stage

        logic              stage_valid;
        logic [DATA_W-1:0] stage_data;

        // Load when empty or when the content leaves this cycle
        assign rdy[k] = ~stage_valid | rdy[k+1];

        always_ff @(posedge aclk) begin
            if (i_rst) begin
                stage_valid <= 1'b0;
            end else if (rdy[k]) begin
                stage_valid <= vld[k];
            end
        end

        always_ff @(posedge aclk) begin
            if (rdy[k] && vld[k]) begin
                stage_data <= dat[k];
            end
        end

        assign vld[k+1] = stage_valid;
        assign dat[k+1] = stage_data;

    end

endmodule

//--- hdl/axicb_pkg.sv
//////////////////////////////
// Crossbar shared constants
//////////////////////////////

package axicb_pkg;

    //////////////////////////////
    // Bus widths
    //////////////////////////////

    // Read address
    localparam int AXI_ADDR_W = 16;
    // Transaction ID
    localparam int AXI_ID_W = 8;
    // Read data
    localparam int AXI_DATA_W = 32;
    // Response code
    localparam int AXI_RESP_W = 2;

    //////////////////////////////
    // Response codes
    //////////////////////////////

    localparam logic [AXI_RESP_W-1:0] RESP_OKAY = 2'd0;
    localparam logic [AXI_RESP_W-1:0] RESP_DECERR = 2'd3;

    //////////////////////////////
    // Field positions
    //////////////////////////////

    // Slave window index over 4 KB windows
    localparam int SLV_SEL_LSB = 12;
    localparam int SLV_SEL_W = 4;

    // Master index carried in the upper ID bits
    localparam int MST_ID_LSB = 4;
    localparam int MST_IDX_W = 4;

endpackage

//--- hdl/axicb_slv_switch.sv
//////////////////////////////
// Master-side read switch
//////////////////////////////

module axicb_slv_switch #(
    parameter int                SLV_NB = 4,
    parameter logic [SLV_NB-1:0] ROUTES = '1
) (
    input  logic                                    aclk,
    input  logic                                    i_rst,
    // AR from the master
    input  logic                                    i_arvalid,
    output logic                                    o_arready,
    input  logic [axicb_pkg::AXI_ADDR_W-1:0]        i_araddr,
    input  logic [axicb_pkg::AXI_ID_W-1:0]          i_arid,
    // AR toward the slaves
    output logic [SLV_NB-1:0]                       o_arvalid,
    input  logic [SLV_NB-1:0]                       i_arready,
    output logic [axicb_pkg::AXI_ADDR_W-1:0]        o_araddr,
    output logic [axicb_pkg::AXI_ID_W-1:0]          o_arid,
    // R from the slaves
    input  logic [SLV_NB-1:0]                       i_rvalid,
    output logic [SLV_NB-1:0]                       o_rready,
    input  logic [SLV_NB*axicb_pkg::AXI_DATA_W-1:0] i_rdata,
    input  logic [SLV_NB*axicb_pkg::AXI_ID_W-1:0]   i_rid,
    input  logic [SLV_NB*axicb_pkg::AXI_RESP_W-1:0] i_rresp,
    // R back to the master
    output logic                                    o_rvalid,
    input  logic                                    i_rready,
    output logic [axicb_pkg::AXI_DATA_W-1:0]        o_rdata,
    output logic [axicb_pkg::AXI_ID_W-1:0]          o_rid,
    output logic [axicb_pkg::AXI_RESP_W-1:0]        o_rresp
);

    import axicb_pkg::*;

    logic [SLV_SEL_W-1:0] win;
    logic [SLV_NB-1:0]    slv_hit;
    logic                 decerr;
    logic                 err_valid;
    logic [AXI_ID_W-1:0]  err_id;
    logic [SLV_NB-1:0]    r_sel;

    //////////////////////////////
    // Address decode
    //////////////////////////////

    assign win = i_araddr[SLV_SEL_LSB +: SLV_SEL_W];

    // Window must exist and be open for this master
    for (genvar s = 0; s < SLV_NB; s++) begin : g_decode
        assign slv_hit[s] = (win == SLV_SEL_W'(s)) && ROUTES[s];
    end

    assign decerr = ~|slv_hit;

    assign o_arvalid = slv_hit & {SLV_NB{i_arvalid & ~err_valid}};
    assign o_arready = ~err_valid & (decerr | |(slv_hit & i_arready));
    assign o_araddr = i_araddr;
    assign o_arid = i_arid;

    // Local error response one cycle after the AR
    always_ff @(posedge aclk) begin
        if (i_rst) begin
            err_valid <= 1'b0;
        end else if (err_valid) begin
            err_valid <= ~i_rready;
        end else if (i_arvalid && decerr) begin
            err_valid <= 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (!err_valid && i_arvalid && decerr) begin
            err_id <= i_arid;
        end
    end

    //////////////////////////////
    // Response merge
    //////////////////////////////

    // DECERR first, then the lowest slave index
    always_comb begin
        o_rvalid = err_valid;
        o_rdata = '0;
        o_rid = err_id;
        o_rresp = RESP_DECERR;
        r_sel = '0;
        if (!err_valid) begin
            for (int s = SLV_NB - 1; s >= 0; s--) begin
                if (i_rvalid[s]) begin
                    o_rvalid = 1'b1;
                    o_rdata = i_rdata[s*AXI_DATA_W +: AXI_DATA_W];
                    o_rid = i_rid[s*AXI_ID_W +: AXI_ID_W];
                    o_rresp = i_rresp[s*AXI_RESP_W +: AXI_RESP_W];
                    r_sel = '0;
                    r_sel[s] = 1'b1;
                end
            end
        end
        o_rready = r_sel & {SLV_NB{i_rready}};
    end

endmodule

//--- hdl/axicb_switch_top.sv
//////////////////////////////
// AXI4-lite read crossbar
//////////////////////////////

module axicb_switch_top #(
    parameter int                       MST_NB = 2,
    parameter int                       SLV_NB = 4,
    parameter int                       MST_PIPELINE = 0,
    parameter int                       SLV_PIPELINE = 0,
    parameter logic [MST_NB*SLV_NB-1:0] MST_ROUTES = '1
) (
    input  logic                                    aclk,
    input  logic                                    i_rst,
    // Master side
    input  logic [MST_NB-1:0]                       i_mst_arvalid,
    output logic [MST_NB-1:0]                       o_mst_arready,
    input  logic [MST_NB*axicb_pkg::AXI_ADDR_W-1:0] i_mst_araddr,
    input  logic [MST_NB*axicb_pkg::AXI_ID_W-1:0]   i_mst_arid,
    output logic [MST_NB-1:0]                       o_mst_rvalid,
    input  logic [MST_NB-1:0]                       i_mst_rready,
    output logic [MST_NB*axicb_pkg::AXI_DATA_W-1:0] o_mst_rdata,
    output logic [MST_NB*axicb_pkg::AXI_ID_W-1:0]   o_mst_rid,
    output logic [MST_NB*axicb_pkg::AXI_RESP_W-1:0] o_mst_rresp,
    // Slave side
    output logic [SLV_NB-1:0]                       o_slv_arvalid,
    input  logic [SLV_NB-1:0]                       i_slv_arready,
    output logic [SLV_NB*axicb_pkg::AXI_ADDR_W-1:0] o_slv_araddr,
    output logic [SLV_NB*axicb_pkg::AXI_ID_W-1:0]   o_slv_arid,
    input  logic [SLV_NB-1:0]                       i_slv_rvalid,
    output logic [SLV_NB-1:0]                       o_slv_rready,
    input  logic [SLV_NB*axicb_pkg::AXI_DATA_W-1:0] i_slv_rdata,
    input  logic [SLV_NB*axicb_pkg::AXI_ID_W-1:0]   i_slv_rid,
    input  logic [SLV_NB*axicb_pkg::AXI_RESP_W-1:0] i_slv_rresp
);

    import axicb_pkg::*;

    localparam int AR_W = AXI_ID_W + AXI_ADDR_W;
    localparam int R_W = AXI_DATA_W + AXI_ID_W + AXI_RESP_W;

    // Handshakes indexed m*SLV_NB+s on the master side, s*MST_NB+m on the slave side
    logic [MST_NB*SLV_NB-1:0]     slv_arvalid, slv_arready, slv_rvalid, slv_rready;
    logic [MST_NB*SLV_NB-1:0]     mst_arvalid, mst_arready, mst_rvalid, mst_rready;
    // Shared payload buses
    logic [MST_NB*AXI_ADDR_W-1:0] sw_araddr;
    logic [MST_NB*AXI_ID_W-1:0]   sw_arid;
    logic [SLV_NB*AXI_DATA_W-1:0] sw_rdata;
    logic [SLV_NB*AXI_ID_W-1:0]   sw_rid;
    logic [SLV_NB*AXI_RESP_W-1:0] sw_rresp;

    //////////////////////////////
    // Master ports
    //////////////////////////////

    for (genvar m = 0; m < MST_NB; m++) begin : g_mst
        logic                  ar_valid, ar_ready, r_valid, r_ready;
        logic [AXI_ADDR_W-1:0] ar_addr;
        logic [AXI_ID_W-1:0]   ar_id, r_id;
        logic [AXI_DATA_W-1:0] r_data;
        logic [AXI_RESP_W-1:0] r_resp;

        axicb_pipeline #(.DATA_W(AR_W), .NB_PIPELINE(SLV_PIPELINE)) u_ar_pipe (
            .aclk(aclk), .i_rst(i_rst),
            .i_valid(i_mst_arvalid[m]), .o_ready(o_mst_arready[m]),
            .i_data({i_mst_arid[m*AXI_ID_W +: AXI_ID_W],
                     i_mst_araddr[m*AXI_ADDR_W +: AXI_ADDR_W]}),
            .o_valid(ar_valid), .i_ready(ar_ready), .o_data({ar_id, ar_addr})
        );

        axicb_pipeline #(.DATA_W(R_W), .NB_PIPELINE(SLV_PIPELINE)) u_r_pipe (
            .aclk(aclk), .i_rst(i_rst),
            .i_valid(r_valid), .o_ready(r_ready), .i_data({r_data, r_id, r_resp}),
            .o_valid(o_mst_rvalid[m]), .i_ready(i_mst_rready[m]),
            .o_data({o_mst_rdata[m*AXI_DATA_W +: AXI_DATA_W],
                     o_mst_rid[m*AXI_ID_W +: AXI_ID_W],
                     o_mst_rresp[m*AXI_RESP_W +: AXI_RESP_W]})
        );

        axicb_slv_switch #(
            .SLV_NB(SLV_NB), .ROUTES(MST_ROUTES[m*SLV_NB +: SLV_NB])
        ) u_slv_switch (
            .aclk(aclk), .i_rst(i_rst),
            .i_arvalid(ar_valid), .o_arready(ar_ready), .i_araddr(ar_addr), .i_arid(ar_id),
            .o_arvalid(slv_arvalid[m*SLV_NB +: SLV_NB]),
            .i_arready(slv_arready[m*SLV_NB +: SLV_NB]),
            .o_araddr(sw_araddr[m*AXI_ADDR_W +: AXI_ADDR_W]),
            .o_arid(sw_arid[m*AXI_ID_W +: AXI_ID_W]),
            .i_rvalid(slv_rvalid[m*SLV_NB +: SLV_NB]),
            .o_rready(slv_rready[m*SLV_NB +: SLV_NB]),
            .i_rdata(sw_rdata), .i_rid(sw_rid), .i_rresp(sw_rresp),
            .o_rvalid(r_valid), .i_rready(r_ready),
            .o_rdata(r_data), .o_rid(r_id), .o_rresp(r_resp)
        );
    end

    // Transpose the master x slave handshake bits
    for (genvar m = 0; m < MST_NB; m++) begin : g_matrix
        for (genvar s = 0; s < SLV_NB; s++) begin : g_cell
            assign mst_arvalid[s*MST_NB+m] = slv_arvalid[m*SLV_NB+s];
            assign slv_arready[m*SLV_NB+s] = mst_arready[s*MST_NB+m];
            assign slv_rvalid[m*SLV_NB+s] = mst_rvalid[s*MST_NB+m];
            assign mst_rready[s*MST_NB+m] = slv_rready[m*SLV_NB+s];
        end
    end

    //////////////////////////////
    // Slave ports
    //////////////////////////////

    for (genvar s = 0; s < SLV_NB; s++) begin : g_slv
        logic                  ar_valid, ar_ready, r_valid, r_ready;
        logic [AXI_ADDR_W-1:0] ar_addr;
        logic [AXI_ID_W-1:0]   ar_id, r_id;
        logic [AXI_DATA_W-1:0] r_data;
        logic [AXI_RESP_W-1:0] r_resp;

        axicb_mst_switch #(.MST_NB(MST_NB)) u_mst_switch (
            .aclk(aclk), .i_rst(i_rst),
            .i_arvalid(mst_arvalid[s*MST_NB +: MST_NB]),
            .o_arready(mst_arready[s*MST_NB +: MST_NB]),
            .i_araddr(sw_araddr), .i_arid(sw_arid),
            .o_arvalid(ar_valid), .i_arready(ar_ready), .o_araddr(ar_addr), .o_arid(ar_id),
            .i_rvalid(r_valid), .o_rready(r_ready),
            .i_rdata(r_data), .i_rid(r_id), .i_rresp(r_resp),
            .o_rvalid(mst_rvalid[s*MST_NB +: MST_NB]),
            .i_rready(mst_rready[s*MST_NB +: MST_NB]),
            .o_rdata(sw_rdata[s*AXI_DATA_W +: AXI_DATA_W]),
            .o_rid(sw_rid[s*AXI_ID_W +: AXI_ID_W]),
            .o_rresp(sw_rresp[s*AXI_RESP_W +: AXI_RESP_W])
        );

        axicb_pipeline #(.DATA_W(AR_W), .NB_PIPELINE(MST_PIPELINE)) u_ar_pipe (
            .aclk(aclk), .i_rst(i_rst),
            .i_valid(ar_valid), .o_ready(ar_ready), .i_data({ar_id, ar_addr}),
            .o_valid(o_slv_arvalid[s]), .i_ready(i_slv_arready[s]),
            .o_data({o_slv_arid[s*AXI_ID_W +: AXI_ID_W],
                     o_slv_araddr[s*AXI_ADDR_W +: AXI_ADDR_W]})
        );

        axicb_pipeline #(.DATA_W(R_W), .NB_PIPELINE(MST_PIPELINE)) u_r_pipe (
            .aclk(aclk), .i_rst(i_rst),
            .i_valid(i_slv_rvalid[s]), .o_ready(o_slv_rready[s]),
            .i_data({i_slv_rdata[s*AXI_DATA_W +: AXI_DATA_W],
                     i_slv_rid[s*AXI_ID_W +: AXI_ID_W],
                     i_slv_rresp[s*AXI_RESP_W +: AXI_RESP_W]}),
            .o_valid(r_valid), .i_ready(r_ready), .o_data({r_data, r_id, r_resp})
        );
    end

endmodule

//--- verification/axicb_clk_gen.sv
//////////////////////////////
// Testbench clock and reset
//////////////////////////////

module axicb_clk_gen #(
    parameter int PERIOD = 100,
    parameter int RST_CYCLES = 4
) (
    output logic o_clk,
    output logic o_rst
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD / 2) o_clk = ~o_clk;
        end
    end

    // Reset released just after the last reset edge
    initial begin
        o_rst = 1'b1;
        repeat (RST_CYCLES) @(posedge o_clk);
        o_rst <= 1'b0;
    end

endmodule

//--- verification/axicb_switch_tb.sv
//////////////////////////////
// Read crossbar testbench
//////////////////////////////

module axicb_switch_tb;

    import axicb_pkg::*;

    localparam int MST_NB = 2;
    localparam int SLV_NB = 4;
    localparam int NB_TESTS = 13;
    localparam int CYCLE_LIMIT = NB_TESTS * 40;
    localparam int SLV_DEPTH = 8;
    // All routes open except master 1 toward slave 3
    localparam logic [MST_NB*SLV_NB-1:0] ROUTES = 8'h7f;

    logic                         aclk, rst;
    logic [MST_NB-1:0]            mst_arvalid, mst_arready, mst_rvalid, mst_rready;
    logic [MST_NB*AXI_ADDR_W-1:0] mst_araddr;
    logic [MST_NB*AXI_ID_W-1:0]   mst_arid, mst_rid;
    logic [MST_NB*AXI_DATA_W-1:0] mst_rdata;
    logic [MST_NB*AXI_RESP_W-1:0] mst_rresp;
    logic [SLV_NB-1:0]            slv_arvalid, slv_arready, slv_rvalid, slv_rready;
    logic [SLV_NB*AXI_ADDR_W-1:0] slv_araddr;
    logic [SLV_NB*AXI_ID_W-1:0]   slv_arid, slv_rid;
    logic [SLV_NB*AXI_DATA_W-1:0] slv_rdata;
    logic [SLV_NB*AXI_RESP_W-1:0] slv_rresp;

    axicb_clk_gen #(.PERIOD(100), .RST_CYCLES(4)) i_clk_gen (.o_clk(aclk), .o_rst(rst));

    axicb_switch_top #(
        .MST_NB(MST_NB), .SLV_NB(SLV_NB), .MST_PIPELINE(1), .SLV_PIPELINE(1),
        .MST_ROUTES(ROUTES)
    ) i_axicb_switch_top (
        .aclk(aclk), .i_rst(rst),
        .i_mst_arvalid(mst_arvalid), .o_mst_arready(mst_arready),
        .i_mst_araddr(mst_araddr), .i_mst_arid(mst_arid),
        .o_mst_rvalid(mst_rvalid), .i_mst_rready(mst_rready), .o_mst_rdata(mst_rdata),
        .o_mst_rid(mst_rid), .o_mst_rresp(mst_rresp),
        .o_slv_arvalid(slv_arvalid), .i_slv_arready(slv_arready),
        .o_slv_araddr(slv_araddr), .o_slv_arid(slv_arid),
        .i_slv_rvalid(slv_rvalid), .o_slv_rready(slv_rready), .i_slv_rdata(slv_rdata),
        .i_slv_rid(slv_rid), .i_slv_rresp(slv_rresp)
    );

    //////////////////////////////
    // Slave models
    //////////////////////////////

    logic [AXI_ADDR_W-1:0] sq_addr [SLV_NB][SLV_DEPTH];
    logic [AXI_ID_W-1:0]   sq_id [SLV_NB][SLV_DEPTH];
    int                    sq_wr [SLV_NB];
    int                    sq_rd [SLV_NB];

    assign slv_arready = '1;

    initial begin
        slv_rvalid = '0;
        slv_rdata = '0;
        slv_rid = '0;
        slv_rresp = '0;
        for (int s = 0; s < SLV_NB; s++) begin
            sq_wr[s] = 0;
            sq_rd[s] = 0;
        end
    end

    // Every AR taken at once, answered in order
    always @(posedge aclk) begin
        for (int s = 0; s < SLV_NB; s++) begin
            if (!rst && slv_rvalid[s] && slv_rready[s] === 1'b1) begin
                sq_rd[s]++;
            end
            if (!rst && slv_arvalid[s] === 1'b1) begin
                sq_addr[s][sq_wr[s] % SLV_DEPTH] = slv_araddr[s*AXI_ADDR_W +: AXI_ADDR_W];
                sq_id[s][sq_wr[s] % SLV_DEPTH] = slv_arid[s*AXI_ID_W +: AXI_ID_W];
                sq_wr[s]++;
            end
        end
        #10;
        for (int s = 0; s < SLV_NB; s++) begin
            slv_rvalid[s] = (sq_rd[s] != sq_wr[s]);
            slv_rdata[s*AXI_DATA_W +: AXI_DATA_W] =
                {8'(s), sq_addr[s][sq_rd[s] % SLV_DEPTH], 8'h00};
            slv_rid[s*AXI_ID_W +: AXI_ID_W] = sq_id[s][sq_rd[s] % SLV_DEPTH];
            slv_rresp[s*AXI_RESP_W +: AXI_RESP_W] = RESP_OKAY;
        end
    end

    //////////////////////////////
    // Stimulus table and checks
    //////////////////////////////

    string                 t_name [NB_TESTS];
    logic [MST_NB-1:0]     t_mask [NB_TESTS];
    logic [AXI_ADDR_W-1:0] t_addr [NB_TESTS];
    logic [3:0]            t_id [NB_TESTS];
    logic [AXI_RESP_W-1:0] t_resp [NB_TESTS];
    int                    nb_loaded;

    logic [MST_NB-1:0]     ar_done, rsp_wait;
    logic [AXI_DATA_W-1:0] exp_data [MST_NB];
    logic [AXI_ID_W-1:0]   exp_id [MST_NB];
    logic [AXI_RESP_W-1:0] exp_resp [MST_NB];
    string                 cur_name;
    logic [31:0]           lcg_state;
    int                    req_count, rsp_count;
    int                    cycle_count = 0;

    function automatic logic [31:0] lcg_next(input logic [31:0] cur);
        return cur * 32'd1664525 + 32'd1013904223;
    endfunction

    // Window index in the top byte, address below, low byte zero
    function automatic logic [AXI_DATA_W-1:0] expected_data(input logic [AXI_ADDR_W-1:0] addr,
                                                           input logic [AXI_RESP_W-1:0] resp);
        if (resp == RESP_DECERR) begin
            return '0;
        end
        return {4'h0, addr[15:12], addr, 8'h00};
    endfunction

    task automatic add_test(input string name, input logic [MST_NB-1:0] mask,
                            input logic [AXI_ADDR_W-1:0] addr, input logic [3:0] id,
                            input logic [AXI_RESP_W-1:0] resp);
        t_name[nb_loaded] = name;
        t_mask[nb_loaded] = mask;
        t_addr[nb_loaded] = addr;
        t_id[nb_loaded] = id;
        t_resp[nb_loaded] = resp;
        nb_loaded++;
    endtask

    task automatic stop_on_error();
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            stop_on_error();
        end
    endtask

    always @(posedge aclk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            stop_on_error();
        end
    end

    // Sample at the edge, drive 10 units later
    task automatic step_cycle();
        @(posedge aclk);
        for (int m = 0; m < MST_NB; m++) begin
            if (mst_arvalid[m] && mst_arready[m]) begin
                ar_done[m] = 1'b1;
                req_count++;
            end
            if (mst_rvalid[m] && mst_rready[m]) begin
                if (!rsp_wait[m]) begin
                    $display("Master %0d got a response with no read outstanding", m);
                    stop_on_error();
                end
                check_value($sformatf("%s rdata m%0d", cur_name, m), exp_data[m],
                            mst_rdata[m*AXI_DATA_W +: AXI_DATA_W]);
                check_value($sformatf("%s rid m%0d", cur_name, m), exp_id[m],
                            mst_rid[m*AXI_ID_W +: AXI_ID_W]);
                check_value($sformatf("%s rresp m%0d", cur_name, m), exp_resp[m],
                            mst_rresp[m*AXI_RESP_W +: AXI_RESP_W]);
                rsp_wait[m] = 1'b0;
                rsp_count++;
            end
        end
        #10;
        mst_arvalid = mst_arvalid & ~ar_done;
        // Random back-pressure on R
        lcg_state = lcg_next(lcg_state);
        mst_rready = lcg_state[31:30];
    endtask

    task automatic run_test(input int t);
        cur_name = t_name[t];
        ar_done = ~t_mask[t];
        rsp_wait = t_mask[t];
        for (int m = 0; m < MST_NB; m++) begin
            exp_data[m] = expected_data(t_addr[t], t_resp[t]);
            exp_id[m] = {4'(m), t_id[t]};
            exp_resp[m] = t_resp[t];
            mst_araddr[m*AXI_ADDR_W +: AXI_ADDR_W] = t_addr[t];
            mst_arid[m*AXI_ID_W +: AXI_ID_W] = {4'(m), t_id[t]};
        end
        mst_arvalid = t_mask[t];
        while (!(&ar_done) || |rsp_wait) begin
            step_cycle();
        end
    endtask

    initial begin
        mst_arvalid = '0;
        mst_araddr = '0;
        mst_arid = '0;
        mst_rready = '0;
        ar_done = '1;
        rsp_wait = '0;
        req_count = 0;
        rsp_count = 0;
        nb_loaded = 0;
        lcg_state = 32'hb520_6c58;
        add_test("routed m0 s0", 2'b01, 16'h0124, 4'h1, RESP_OKAY);
        add_test("routed m0 s1", 2'b01, 16'h1a58, 4'h2, RESP_OKAY);
        add_test("routed m0 s2", 2'b01, 16'h2ffc, 4'h3, RESP_OKAY);
        add_test("routed m0 s3", 2'b01, 16'h3004, 4'h4, RESP_OKAY);
        add_test("routed m1 s0", 2'b10, 16'h0f00, 4'h5, RESP_OKAY);
        add_test("routed m1 s1", 2'b10, 16'h1234, 4'h6, RESP_OKAY);
        add_test("routed m1 s2", 2'b10, 16'h2c0c, 4'h7, RESP_OKAY);
        add_test("unmapped m0", 2'b01, 16'h4010, 4'h8, RESP_DECERR);
        add_test("unmapped m1", 2'b10, 16'hf123, 4'h9, RESP_DECERR);
        add_test("masked m1 s3", 2'b10, 16'h3abc, 4'ha, RESP_DECERR);
        add_test("open m0 s3", 2'b01, 16'h3abc, 4'hb, RESP_OKAY);
        add_test("contention s2", 2'b11, 16'h2468, 4'hc, RESP_OKAY);
        add_test("contention s1", 2'b11, 16'h1010, 4'hd, RESP_OKAY);
        wait (rst === 1'b0);
        #10;
        // Idle outputs after reset
        repeat (4) begin
            @(posedge aclk);
            check_value("reset o_mst_rvalid", 0, mst_rvalid);
            check_value("reset o_slv_arvalid", 0, slv_arvalid);
            #10;
        end
        for (int t = 0; t < NB_TESTS; t++) begin
            run_test(t);
        end
        // Late or duplicated responses show up here
        repeat (6) step_cycle();
        check_value("response count", req_count, rsp_count);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule
